// File: ex_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, opcode enums and bus structs for
// the execute stage; imported by every block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // peripheral window for uart and accelerator registers
    localparam logic [XLEN-1:0] MMIO_BASE = 32'h8000_0000;
    localparam logic [XLEN-1:0] MMIO_MASK = 32'hFFFF_F000;

    // load/store width from funct3
    localparam logic [2:0] F3_BYTE = 3'd0;
    localparam logic [2:0] F3_HALF = 3'd1;
    localparam logic [2:0] F3_WORD = 3'd2;

    // branch conditions from funct3
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic {SRC_A_REG, SRC_A_PC} src_a_e;
    typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;
    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;
    typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_JALR} jump_e;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1_addr;
        logic [REG_AW-1:0] rs2_addr;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd_addr;
        alu_op_e           alu_op;
        src_a_e            src_a;
        src_b_e            src_b;
        logic [2:0]        funct3;
        logic              branch;
        jump_e             jump;
        mem_op_e           mem_op;
        logic              wb_en;
    } ex_req_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   data;
    } wb_fwd_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   alu_result;
        logic [REG_AW-1:0] rd_addr;
        logic              wb_en;
        logic [XLEN-1:0]   pc_plus4;
        logic              redirect;
        logic [XLEN-1:0]   redirect_pc;
        mem_op_e           mem_op;
        logic [3:0]        mem_be;
        logic [XLEN-1:0]   mem_wdata;
        logic [XLEN-1:0]   mmio_rdata;
        logic              mmio_err;
    } ex_resp_t;

    typedef struct packed {
        logic            psel;
        logic            penable;
        logic            pwrite;
        logic [XLEN-1:0] paddr;
        logic [XLEN-1:0] pwdata;
        logic [3:0]      pstrb;
    } apb_req_t;

    typedef struct packed {
        logic            pready;
        logic [XLEN-1:0] prdata;
        logic            pslverr;
    } apb_rsp_t;

endpackage

// File: ex_operand_fwd.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand select with writeback forwarding for the
// alu, branch compare and store data paths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ex_operand_fwd (
    input  ex_pkg::ex_req_t req_i,
    input  ex_pkg::wb_fwd_t wb_i,
    output logic [31:0]     alu_a_o,
    output logic [31:0]     alu_b_o,
    output logic [31:0]     cmp_a_o,
    output logic [31:0]     cmp_b_o,
    output logic [31:0]     store_data_o
);
    import ex_pkg::*;

    logic            fwd_rs1;
    logic            fwd_rs2;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    // x0 always reads zero so it never takes the bypass
    assign fwd_rs1 = wb_i.valid && (wb_i.rd_addr == req_i.rs1_addr)
                     && (req_i.rs1_addr != '0);
    assign fwd_rs2 = wb_i.valid && (wb_i.rd_addr == req_i.rs2_addr)
                     && (req_i.rs2_addr != '0);

    assign rs1_val = fwd_rs1 ? wb_i.data : req_i.rs1_data;
    assign rs2_val = fwd_rs2 ? wb_i.data : req_i.rs2_data;

    // auipc / jal use pc as operand a
    assign alu_a_o = (req_i.src_a == SRC_A_PC) ? req_i.pc : rs1_val;
    assign alu_b_o = (req_i.src_b == SRC_B_IMM) ? req_i.imm : rs2_val;

    assign cmp_a_o      = rs1_val;
    assign cmp_b_o      = rs2_val;
    assign store_data_o = rs2_val;

endmodule

// File: ex_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational rv32i integer alu
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ex_alu (
    input  ex_pkg::alu_op_e op_i,
    input  logic [31:0]     a_i,
    input  logic [31:0]     b_i,
    output logic [31:0]     result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                result_o = a_i + b_i;
            end
            ALU_SUB: begin
                result_o = a_i - b_i;
            end
            ALU_SLL: begin
                result_o = a_i << shamt;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
            end
            ALU_XOR: result_o = a_i ^ b_i;
            ALU_SRL: result_o = a_i >> shamt;
            ALU_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            // lui passes the immediate straight through
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0;
        endcase
    end

endmodule

// File: ex_branch_comp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch condition check; flags a redirect for a
// taken branch or any jump
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ex_branch_comp (
    input  logic [2:0]    funct3_i,
    input  logic          branch_i,
    input  ex_pkg::jump_e jump_i,
    input  logic [31:0]   a_i,
    input  logic [31:0]   b_i,
    output logic          redirect_o
);
    import ex_pkg::*;

    logic taken;

    always_comb begin
        case (funct3_i)
            F3_BEQ:  taken = (a_i == b_i);
            F3_BNE:  taken = (a_i != b_i);
            F3_BLT:  taken = ($signed(a_i) < $signed(b_i));
            F3_BGE:  taken = ($signed(a_i) >= $signed(b_i));
            F3_BLTU: taken = (a_i < b_i);
            F3_BGEU: taken = (a_i >= b_i);
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = (branch_i && taken) || (jump_i != JUMP_NONE);

endmodule

// File: ex_store_align.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store byte enables and lane-replicated write data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ex_store_align (
    input  logic [2:0]  width_i,
    input  logic        store_i,
    input  logic [1:0]  offset_i,
    input  logic [31:0] data_i,
    output logic [3:0]  be_o,
    output logic [31:0] wdata_o
);
    import ex_pkg::*;

    logic [3:0] lane_be;

    always_comb begin
        case (width_i)
            F3_BYTE: begin
                lane_be = 4'b0001 << offset_i;
                wdata_o = {4{data_i[7:0]}};
            end
            F3_HALF: begin
                // halves sit on lanes 0-1 or 2-3
                lane_be = offset_i[1] ? 4'b1100 : 4'b0011;
                wdata_o = {2{data_i[15:0]}};
            end
            F3_WORD: begin
                lane_be = 4'b1111;
                wdata_o = data_i;
            end
            default: begin
                lane_be = 4'b0000;
                wdata_o = data_i;
            end
        endcase
    end

    // loads and bubbles never touch memory
    assign be_o = store_i ? lane_be : 4'b0000;

endmodule

// File: ex_apb_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// apb master for one peripheral access per start;
// done pulses in the cycle pready is seen
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ex_apb_bridge (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             start_i,
    input  logic             write_i,
    input  logic [31:0]      addr_i,
    input  logic [31:0]      wdata_i,
    input  logic [3:0]       strb_i,
    output ex_pkg::apb_req_t apb_o,
    input  ex_pkg::apb_rsp_t apb_i,
    output logic             done_o,
    output logic [31:0]      rdata_o,
    output logic             err_o
);
    import ex_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} state_e;

    state_e          state_q;
    state_e          state_d;
    logic            write_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] wdata_q;
    logic [3:0]      strb_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = SETUP;
                end
            end
            SETUP:  state_d = ACCESS;
            ACCESS: begin
                if (apb_i.pready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // transfer fields held stable for both phases
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            write_q <= write_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            strb_q  <= strb_i;
        end
    end

    assign apb_o.psel    = (state_q != IDLE);
    assign apb_o.penable = (state_q == ACCESS);
    assign apb_o.pwrite  = write_q;
    assign apb_o.paddr   = addr_q;
    assign apb_o.pwdata  = wdata_q;
    assign apb_o.pstrb   = strb_q;

    assign done_o  = (state_q == ACCESS) && apb_i.pready;
    // read data only meaningful for reads
    assign rdata_o = (done_o && !write_q) ? apb_i.prdata : '0;
    assign err_o   = done_o && apb_i.pslverr;

endmodule

// File: ex_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage top with alu, branch resolve, store
// alignment and apb path around one registered result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ex_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  ex_pkg::ex_req_t  req_i,
    input  ex_pkg::wb_fwd_t  wb_i,
    output logic             stall_o,
    output ex_pkg::ex_resp_t resp_o,
    output ex_pkg::apb_req_t apb_o,
    input  ex_pkg::apb_rsp_t apb_i
);
    import ex_pkg::*;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] cmp_a;
    logic [XLEN-1:0] cmp_b;
    logic [XLEN-1:0] store_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] store_wdata;
    logic [3:0]      store_be;
    logic            redirect;
    logic            is_store;
    logic            mmio_hit;
    logic            busy_q;
    logic            apb_start;
    logic            apb_done;
    logic            apb_err;
    logic [XLEN-1:0] apb_rdata;
    ex_resp_t        resp_d;
    ex_resp_t        resp_q;

    ex_operand_fwd u_fwd (
        .req_i        (req_i),
        .wb_i         (wb_i),
        .alu_a_o      (alu_a),
        .alu_b_o      (alu_b),
        .cmp_a_o      (cmp_a),
        .cmp_b_o      (cmp_b),
        .store_data_o (store_data)
    );

    ex_alu u_alu (
        .op_i     (req_i.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    ex_branch_comp u_branch (
        .funct3_i   (req_i.funct3),
        .branch_i   (req_i.branch),
        .jump_i     (req_i.jump),
        .a_i        (cmp_a),
        .b_i        (cmp_b),
        .redirect_o (redirect)
    );

    assign is_store = req_i.valid && (req_i.mem_op == MEM_STORE);

    ex_store_align u_store (
        .width_i  (req_i.funct3),
        .store_i  (is_store),
        .offset_i (alu_result[1:0]),
        .data_i   (store_data),
        .be_o     (store_be),
        .wdata_o  (store_wdata)
    );

    // peripheral window decode on the computed address
    assign mmio_hit = req_i.valid && (req_i.mem_op != MEM_NONE)
                      && ((alu_result & MMIO_MASK) == MMIO_BASE);
    assign apb_start = mmio_hit && !busy_q;
    assign stall_o   = mmio_hit && !apb_done;

    ex_apb_bridge u_apb (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (apb_start),
        .write_i (is_store),
        .addr_i  (alu_result),
        .wdata_i (store_wdata),
        .strb_i  (store_be),
        .apb_o   (apb_o),
        .apb_i   (apb_i),
        .done_o  (apb_done),
        .rdata_o (apb_rdata),
        .err_o   (apb_err)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (apb_done) begin
            busy_q <= 1'b0;
        end else if (apb_start) begin
            busy_q <= 1'b1;
        end
    end

    always_comb begin
        resp_d             = '0;
        resp_d.valid       = req_i.valid;
        resp_d.alu_result  = alu_result;
        resp_d.rd_addr     = req_i.rd_addr;
        resp_d.wb_en       = req_i.wb_en;
        resp_d.pc_plus4    = req_i.pc + 32'd4;
        resp_d.redirect    = req_i.valid && redirect;
        // jalr target drops bit 0
        resp_d.redirect_pc = (req_i.jump == JUMP_JALR) ? {alu_result[XLEN-1:1], 1'b0}
                                                       : req_i.pc + req_i.imm;
        resp_d.mem_op      = req_i.mem_op;
        resp_d.mem_be      = mmio_hit ? 4'b0000 : store_be;
        resp_d.mem_wdata   = store_wdata;
        resp_d.mmio_rdata  = mmio_hit ? apb_rdata : '0;
        resp_d.mmio_err    = mmio_hit && apb_err;
    end

    // no result leaves while the apb access is pending
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            resp_q <= '0;
        end else if (!stall_o) begin
            resp_q <= resp_d;
        end else begin
            resp_q.valid <= 1'b0;
        end
    end

    assign resp_o = resp_q;

endmodule

// File: tb_ex_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for the execute stage with a
// reference model and an apb slave model; built from all.f
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_ex_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int N_RESET     = 4;
    localparam int N_ALU       = 200;
    localparam int N_FWD       = 150;
    localparam int N_BR        = 150;
    localparam int N_STORE_REP = 4;
    localparam int N_APB       = 40;
    localparam int TOTAL_REQS  = N_RESET + N_ALU + N_FWD + N_BR + 12 * N_STORE_REP + N_APB;

    logic     clk_i;
    logic     rst_n_i;
    ex_req_t  req_i;
    wb_fwd_t  wb_i;
    logic     stall_o;
    ex_resp_t resp_o;
    apb_req_t apb_o;
    apb_rsp_t apb_i;

    integer   seed = 32'h0e58a957;
    int       checks = 0;
    int       errors = 0;
    apb_req_t exp_apb;
    int       wait_left;
    int       last_wait;
    logic     prev_sel;

    ex_stage dut0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .wb_i    (wb_i),
        .stall_o (stall_o),
        .resp_o  (resp_o),
        .apb_o   (apb_o),
        .apb_i   (apb_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(2 * TOTAL_REQS * 6 * CLK_PERIOD);
        $display("timeout: the stage stopped completing requests");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = rnd();
        return r % n;
    endfunction

    // peripheral register contents seen by the slave model
    function automatic logic [31:0] slave_rdata(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'h5a3c_a5c3;
    endfunction

    // reserved offset answers with an error
    function automatic logic slave_err(input logic [31:0] addr);
        return addr[11:0] == 12'hffc;
    endfunction

    function automatic ex_resp_t model_resp(input ex_req_t r, input wb_fwd_t w,
                                            output apb_req_t ap, output logic mmio);
        ex_resp_t    e;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        taken;
        logic [3:0]  be;
        logic [31:0] wd;
        rs1 = (w.valid && w.rd_addr != 5'd0 && w.rd_addr == r.rs1_addr) ? w.data : r.rs1_data;
        rs2 = (w.valid && w.rd_addr != 5'd0 && w.rd_addr == r.rs2_addr) ? w.data : r.rs2_data;
        a = (r.src_a == SRC_A_PC) ? r.pc : rs1;
        b = (r.src_b == SRC_B_IMM) ? r.imm : rs2;
        case (r.alu_op)
            ALU_ADD:    res = a + b;
            ALU_SUB:    res = a - b;
            ALU_SLL:    res = a << b[4:0];
            ALU_SLT:    res = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   res = {31'd0, a < b};
            ALU_XOR:    res = a ^ b;
            ALU_SRL:    res = a >> b[4:0];
            ALU_SRA:    res = $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:     res = a | b;
            ALU_AND:    res = a & b;
            ALU_PASS_B: res = b;
            default:    res = 32'd0;
        endcase
        case (r.funct3)
            3'd0:    taken = rs1 == rs2;
            3'd1:    taken = rs1 != rs2;
            3'd4:    taken = $signed(rs1) < $signed(rs2);
            3'd5:    taken = $signed(rs1) >= $signed(rs2);
            3'd6:    taken = rs1 < rs2;
            3'd7:    taken = rs1 >= rs2;
            default: taken = 1'b0;
        endcase
        be = 4'b0000;
        wd = rs2;
        if (r.funct3 == 3'd0) begin
            be = 4'b0001 << res[1:0];
            wd = {4{rs2[7:0]}};
        end else if (r.funct3 == 3'd1) begin
            be = res[1] ? 4'b1100 : 4'b0011;
            wd = {2{rs2[15:0]}};
        end else if (r.funct3 == 3'd2) begin
            be = 4'b1111;
        end
        if (!(r.valid && r.mem_op == MEM_STORE)) begin
            be = 4'b0000;
        end
        mmio = r.valid && r.mem_op != MEM_NONE && (res & MMIO_MASK) == MMIO_BASE;
        ap = '{psel: 1'b1, penable: 1'b0, pwrite: r.mem_op == MEM_STORE,
               paddr: res, pwdata: wd, pstrb: be};
        e = '0;
        e.valid       = r.valid;
        e.alu_result  = res;
        e.rd_addr     = r.rd_addr;
        e.wb_en       = r.wb_en;
        e.pc_plus4    = r.pc + 32'd4;
        e.redirect    = r.valid && ((r.branch && taken) || r.jump != JUMP_NONE);
        e.redirect_pc = (r.jump == JUMP_JALR) ? {res[31:1], 1'b0} : r.pc + r.imm;
        e.mem_op      = r.mem_op;
        e.mem_be      = mmio ? 4'b0000 : be;
        e.mem_wdata   = wd;
        e.mmio_rdata  = (mmio && r.mem_op == MEM_LOAD) ? slave_rdata(res) : 32'd0;
        e.mmio_err    = mmio && slave_err(res);
        return e;
    endfunction

    task automatic compare_resp(input ex_resp_t got, input ex_resp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_apb(input apb_req_t got, input apb_req_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // apb slave model answering 1 ns after each edge
    initial begin
        apb_i = '0;
        prev_sel = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            apb_i = '0;
            if (apb_o.psel && !apb_o.penable) begin
                if (prev_sel) begin
                    errors++;
                    $display("apb setup phase lasted more than one cycle at %0t", $time);
                end
                exp_apb.penable = 1'b0;
                compare_apb(apb_o, exp_apb, "apb setup");
                wait_left = pick(4);
                last_wait = wait_left;
            end else if (apb_o.psel) begin
                if (!prev_sel) begin
                    errors++;
                    $display("apb access phase began without a setup phase at %0t", $time);
                end
                exp_apb.penable = 1'b1;
                compare_apb(apb_o, exp_apb, "apb access");
                if (wait_left == 0) begin
                    apb_i.pready  = 1'b1;
                    apb_i.prdata  = slave_rdata(apb_o.paddr);
                    apb_i.pslverr = slave_err(apb_o.paddr);
                end else begin
                    wait_left--;
                end
            end
            prev_sel = apb_o.psel;
        end
    end

    function automatic ex_req_t rand_req();
        ex_req_t     r;
        logic [31:0] t;
        t = rnd();
        r = '0;
        r.valid    = 1'b1;
        r.pc       = rnd() & 32'h7fff_fffc;
        r.rs1_addr = t[4:0];
        r.rs2_addr = t[9:5];
        r.rd_addr  = t[14:10];
        r.funct3   = t[17:15];
        r.wb_en    = t[18];
        r.src_a    = src_a_e'(t[19]);
        r.src_b    = src_b_e'(t[20]);
        r.alu_op   = alu_op_e'(4'(pick(11)));
        r.rs1_data = rnd();
        r.rs2_data = rnd();
        r.imm      = rnd();
        r.jump     = JUMP_NONE;
        r.mem_op   = MEM_NONE;
        return r;
    endfunction

    // called 2 ns after an edge and returns 2 ns after the result edge
    task automatic issue(input ex_req_t r, input wb_fwd_t w);
        ex_resp_t exp;
        apb_req_t ap;
        logic     mmio;
        int       cycles;
        exp = model_resp(r, w, ap, mmio);
        exp_apb = ap;
        req_i = r;
        wb_i = w;
        #1;
        compare_flag(stall_o, mmio, "stall_o after issue");
        if (mmio) begin
            cycles = 0;
            do begin
                @(posedge clk_i);
                #3;
                cycles++;
            end while (stall_o);
            checks++;
            if (cycles != 2 + last_wait) begin
                errors++;
                $display("FAIL %0t: stall lasted %0d cycles, expected %0d",
                         $time, cycles, 2 + last_wait);
            end
        end
        @(posedge clk_i);
        #1;
        compare_resp(resp_o, exp, "resp_o");
        #1;
    endtask

    task automatic report(input string name, input int n, input int err0);
        $display("test %-7s %4d requests, %0d errors", name, n, errors - err0);
    endtask

    initial begin
        ex_req_t     r;
        wb_fwd_t     w;
        int          err0;
        int unsigned f;
        logic [31:0] t;
        rst_n_i = 1'b0;
        req_i = '0;
        wb_i = '0;
        repeat (10) @(posedge clk_i);
        #2;
        err0 = errors;
        compare_flag(resp_o.valid, 1'b0, "resp_o.valid in reset");
        compare_flag(apb_o.psel, 1'b0, "psel in reset");
        compare_flag(apb_o.penable, 1'b0, "penable in reset");
        compare_flag(stall_o, 1'b0, "stall_o in reset");
        rst_n_i = 1'b1;
        repeat (N_RESET) begin
            r = rand_req();
            r.valid = 1'b0;
            w = '0;
            issue(r, w);
        end
        report("reset", N_RESET, err0);

        err0 = errors;
        repeat (N_ALU) begin
            r = rand_req();
            w = '0;
            issue(r, w);
        end
        report("alu", N_ALU, err0);

        // bypass hits on rs1 or rs2 with the odd one on x0
        err0 = errors;
        repeat (N_FWD) begin
            r = rand_req();
            r.branch = (pick(2) != 0);
            r.mem_op = (pick(2) != 0) ? MEM_STORE : MEM_NONE;
            w.valid = 1'b1;
            w.data = rnd();
            w.rd_addr = (pick(2) != 0) ? r.rs1_addr : r.rs2_addr;
            if (pick(8) == 0) begin
                r.rs1_addr = 5'd0;
                w.rd_addr = 5'd0;
            end
            issue(r, w);
        end
        report("forward", N_FWD, err0);

        err0 = errors;
        repeat (N_BR) begin
            r = rand_req();
            f = pick(6);
            r.funct3 = 3'(f < 2 ? f : f + 2);
            r.jump = jump_e'(2'(pick(3)));
            r.branch = (r.jump == JUMP_NONE);
            if (pick(4) == 0) begin
                r.rs2_data = r.rs1_data;
            end
            w = '0;
            issue(r, w);
        end
        report("branch", N_BR, err0);

        err0 = errors;
        for (int wd = 0; wd < 3; wd++) begin
            for (int off = 0; off < 4; off++) begin
                repeat (N_STORE_REP) begin
                    r = rand_req();
                    r.src_a = SRC_A_REG;
                    r.src_b = SRC_B_IMM;
                    r.alu_op = ALU_ADD;
                    r.mem_op = MEM_STORE;
                    r.funct3 = 3'(wd);
                    r.rs1_data = rnd() & 32'h3fff_fffc;
                    r.imm = 32'(off);
                    w = '0;
                    issue(r, w);
                end
            end
        end
        report("store", 12 * N_STORE_REP, err0);

        err0 = errors;
        repeat (N_APB) begin
            r = rand_req();
            r.src_a = SRC_A_REG;
            r.src_b = SRC_B_IMM;
            r.alu_op = ALU_ADD;
            r.funct3 = 3'(pick(3));
            r.mem_op = (pick(2) != 0) ? MEM_STORE : MEM_LOAD;
            r.rs1_data = MMIO_BASE;
            t = rnd();
            r.imm = (pick(4) == 0) ? 32'h0000_0ffc : {20'd0, t[11:0]};
            w = '0;
            issue(r, w);
        end
        report("apb", N_APB, err0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
ex_pkg.sv
ex_operand_fwd.sv
ex_alu.sv
ex_branch_comp.sv
ex_store_align.sv
ex_apb_bridge.sv
ex_stage.sv
tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f all.f --top-module tb_ex_stage -o sim_ex_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
